// File: project.f
+incdir+hw
hw/sba_pkg.sv
hw/sba_req_fifo.sv
hw/sba_mem_port.sv
hw/dmi_sba_regs.sv
hw/sba_loader_top.sv
testbench/sba_loader_assert.sv
testbench/tb_sba_loader.sv

// File: Makefile
# Verilator build and run for the SBA load path

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_sba_loader
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hw/sba_macros.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+100 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_sba_loader.sv
//////////////////////////////
// Testbench for the SBA load path. Drives DMI
// strobes on the falling edge, keeps a word model
// of the SRAM and runs five directed tests.
//////////////////////////////

`default_nettype none

`include "sba_macros.svh"

module tb_sba_loader;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DEPTH      = `SBA_FIFO_DEPTH;
   localparam int MEM_WORDS  = `SBA_MEM_WORDS;
   localparam int MAX_CYCLES = 4000;
   // SBCS field positions from the debug spec
   localparam int BUSYERR_BIT = 22;
   localparam int BUSY_BIT    = 21;
   localparam int ERR_LO      = 12;
   // mem_ready_i patterns
   localparam int RDY_LOW    = 0;
   localparam int RDY_HIGH   = 1;
   localparam int RDY_RANDOM = 2;

   logic               clk_sys;
   logic               rst_i;
   logic               dmi_req;
   logic               dmi_we;
   sba_pkg::dmi_addr_t dmi_addr;
   sba_pkg::sba_word_t dmi_wdata;
   sba_pkg::sba_word_t dmi_rdata;
   logic               mem_ready = 1'b1;

   integer seed = 32'h92dd22b8;
   int ready_mode = RDY_HIGH;
   int rnd_ready;
   int cycles = 0;
   int checks = 0;
   int errors = 0;
   // expected SRAM words by index
   sba_pkg::sba_word_t model_mem [int];

   sba_loader_top u_dut (
      .clk_sys     (clk_sys),
      .rst_i       (rst_i),
      .dmi_req_i   (dmi_req),
      .dmi_we_i    (dmi_we),
      .dmi_addr_i  (dmi_addr),
      .dmi_wdata_i (dmi_wdata),
      .dmi_rdata_o (dmi_rdata),
      .mem_ready_i (mem_ready)
   );

   initial begin
      clk_sys = 1'b0;
      forever #5 clk_sys = ~clk_sys;
   end

   // run limit
   always @(posedge clk_sys) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks failed");
         $finish;
      end
   end

   // stall pattern of the memory slave
   always @(negedge clk_sys) begin
      if (ready_mode == RDY_RANDOM) begin
         rnd_ready = $random(seed);
         mem_ready = rnd_ready[0];
      end else begin
         mem_ready = (ready_mode == RDY_HIGH);
      end
   end

   // byte address to SRAM word, wraps like the array
   function automatic int word_idx(input sba_pkg::sba_word_t addr);
      return int'((addr >> 2) % MEM_WORDS);
   endfunction

   function automatic sba_pkg::sba_word_t sbcs_val(input logic rd_on_addr,
         input logic [2:0] access, input logic autoinc, input logic rd_on_data);
      sba_pkg::sba_word_t v;
      v        = '0;
      v[20]    = rd_on_addr;
      v[19:17] = access;
      v[16]    = autoinc;
      v[15]    = rd_on_data;
      return v;
   endfunction

   // one-cycle write strobe
   task automatic dmi_write(input sba_pkg::dmi_addr_t addr, input sba_pkg::sba_word_t data);
      @(negedge clk_sys);
      dmi_req   = 1'b1;
      dmi_we    = 1'b1;
      dmi_addr  = addr;
      dmi_wdata = data;
      @(negedge clk_sys);
      dmi_req = 1'b0;
      dmi_we  = 1'b0;
   endtask

   // data is registered, taken one cycle later
   task automatic dmi_read(input sba_pkg::dmi_addr_t addr, output sba_pkg::sba_word_t data);
      @(negedge clk_sys);
      dmi_req  = 1'b1;
      dmi_we   = 1'b0;
      dmi_addr = addr;
      @(negedge clk_sys);
      dmi_req = 1'b0;
      data    = dmi_rdata;
   endtask

   // poll SBCS until sbbusy drops
   task automatic wait_idle();
      sba_pkg::sba_word_t sbcs;
      do begin
         dmi_read(sba_pkg::DMI_SBCS, sbcs);
      end while (sbcs[BUSY_BIT]);
   endtask

   task automatic check_word(input string name, input sba_pkg::sba_word_t exp,
         input sba_pkg::sba_word_t got);
      checks++;
      assert (got === exp) else begin
         $display("** Error %s: expected %h, got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic end_test(input int num, input string name, input int err_before);
      $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
   endtask

   initial begin
      sba_pkg::sba_word_t rd;
      sba_pkg::sba_word_t wdata;
      sba_pkg::sba_word_t base;
      int err_before;
      int fails;
      int i;
      rst_i     = 1'b1;
      dmi_req   = 1'b0;
      dmi_we    = 1'b0;
      dmi_addr  = '0;
      dmi_wdata = '0;
      repeat (4) @(posedge clk_sys);
      @(negedge clk_sys);
      rst_i = 1'b0;

      // registers after reset
      err_before = errors;
      dmi_read(sba_pkg::DMI_SBCS, rd);
      check_word("sbcs", 32'h0, rd);
      dmi_read(sba_pkg::DMI_SBADDR0, rd);
      check_word("sbaddress0", 32'h0, rd);
      dmi_read(sba_pkg::DMI_SBDATA0, rd);
      check_word("sbdata0", 32'h0, rd);
      end_test(1, "reset values", err_before);

      // program preload with a randomly stalling slave
      err_before = errors;
      base       = 32'h100;
      ready_mode = RDY_RANDOM;
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b0, 3'd2, 1'b1, 1'b0));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      for (i = 0; i < 16; i++) begin
         wdata = $random(seed);
         dmi_write(sba_pkg::DMI_SBDATA0, wdata);
         model_mem[word_idx(base + 32'(4 * i))] = wdata;
         // bursts of four stay within the buffer
         if (i % 4 == 3) begin
            wait_idle();
         end
      end
      dmi_read(sba_pkg::DMI_SBCS, rd);
      check_word("sbcs.sbbusyerror", 32'h0, 32'(rd[BUSYERR_BIT]));
      // read on address starts the first fetch
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b1, 3'd2, 1'b1, 1'b1));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      for (i = 0; i < 16; i++) begin
         wait_idle();
         dmi_read(sba_pkg::DMI_SBDATA0, rd);
         check_word("sbdata0", model_mem[word_idx(base + 32'(4 * i))], rd);
      end
      wait_idle();
      ready_mode = RDY_HIGH;
      end_test(2, "preload and readback", err_before);

      // same address three times, last one wins
      err_before = errors;
      base       = 32'h200;
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b0, 3'd2, 1'b0, 1'b0));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      for (i = 0; i < 3; i++) begin
         wdata = $random(seed);
         dmi_write(sba_pkg::DMI_SBDATA0, wdata);
      end
      model_mem[word_idx(base)] = wdata;
      wait_idle();
      dmi_read(sba_pkg::DMI_SBADDR0, rd);
      check_word("sbaddress0", base, rd);
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b1, 3'd2, 1'b0, 1'b0));
      // fetch a preload word first so SBData0 no longer holds the host write
      dmi_write(sba_pkg::DMI_SBADDR0, 32'h100);
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      wait_idle();
      dmi_read(sba_pkg::DMI_SBDATA0, rd);
      check_word("sbdata0", model_mem[word_idx(base)], rd);
      end_test(3, "no auto-increment", err_before);

      // fill the buffer against a stopped slave
      // word after the last one keeps its preload value
      err_before = errors;
      base       = 32'h120;
      ready_mode = RDY_LOW;
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b0, 3'd2, 1'b1, 1'b0));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      for (i = 0; i <= DEPTH; i++) begin
         wdata = $random(seed);
         dmi_write(sba_pkg::DMI_SBDATA0, wdata);
         if (i < DEPTH) begin
            model_mem[word_idx(base + 32'(4 * i))] = wdata;
         end
      end
      dmi_read(sba_pkg::DMI_SBCS, rd);
      check_word("sbcs.sbbusyerror", 32'h1, 32'(rd[BUSYERR_BIT]));
      ready_mode = RDY_HIGH;
      wait_idle();
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b1, 3'd2, 1'b1, 1'b1));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      for (i = 0; i <= DEPTH; i++) begin
         wait_idle();
         dmi_read(sba_pkg::DMI_SBDATA0, rd);
         check_word("sbdata0", model_mem[word_idx(base + 32'(4 * i))], rd);
      end
      wait_idle();
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b0, 3'd2, 1'b0, 1'b0) | (32'd1 << BUSYERR_BIT));
      dmi_read(sba_pkg::DMI_SBCS, rd);
      check_word("sbcs.sbbusyerror", 32'h0, 32'(rd[BUSYERR_BIT]));
      end_test(4, "buffer overflow", err_before);

      // 16-bit access is refused
      err_before = errors;
      base       = 32'h200;
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b0, 3'd1, 1'b0, 1'b0));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      dmi_write(sba_pkg::DMI_SBDATA0, ~model_mem[word_idx(base)]);
      dmi_read(sba_pkg::DMI_SBCS, rd);
      check_word("sbcs.sberror", 32'h4, 32'(rd[ERR_LO+2:ERR_LO]));
      dmi_write(sba_pkg::DMI_SBCS, sbcs_val(1'b1, 3'd2, 1'b0, 1'b0) | (32'd7 << ERR_LO));
      dmi_read(sba_pkg::DMI_SBCS, rd);
      check_word("sbcs.sberror", 32'h0, 32'(rd[ERR_LO+2:ERR_LO]));
      dmi_write(sba_pkg::DMI_SBADDR0, base);
      wait_idle();
      dmi_read(sba_pkg::DMI_SBDATA0, rd);
      check_word("sbdata0", model_mem[word_idx(base)], rd);
      end_test(5, "unsupported access size", err_before);

      fails = u_dut.u_assert.fail_cnt;
      $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, fails);
      if (errors == 0 && fails == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/sba_loader_assert.sv
//////////////////////////////
// Protocol checks on the SBA load path.
// Bound into sba_loader_top; fail_cnt holds the
// number of failed checks for the testbench.
//////////////////////////////

`default_nettype none

module sba_loader_assert (
   input logic clk_sys,
   input logic rst_i,
   input logic push_i,
   input logic full_i,
   input logic pop_i,
   input logic done_i,
   input logic mem_ready_i,
   input logic not_empty_i,
   input logic sbbusy_i
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;

   // front end must respect the buffer level
   push_not_full: assert property (@(posedge clk_sys) disable iff (rst_i)
      push_i |-> !full_i)
      else begin
         fail_cnt++;
         $error("push while the request buffer is full");
      end

   // every access completes on the next edge
   done_after_pop: assert property (@(posedge clk_sys) disable iff (rst_i)
      pop_i |=> done_i)
      else begin
         fail_cnt++;
         $error("no done one cycle after a pop");
      end

   // and no completion without an access
   done_needs_pop: assert property (@(posedge clk_sys) disable iff (rst_i)
      done_i |-> $past(pop_i))
      else begin
         fail_cnt++;
         $error("done without a pop in the cycle before");
      end

   // stalled memory takes nothing
   pop_needs_ready: assert property (@(posedge clk_sys) disable iff (rst_i)
      !mem_ready_i |-> !pop_i)
      else begin
         fail_cnt++;
         $error("pop while mem_ready_i is low");
      end

   // queued work counts as busy
   busy_with_queue: assert property (@(posedge clk_sys) disable iff (rst_i)
      not_empty_i |-> sbbusy_i)
      else begin
         fail_cnt++;
         $error("sbbusy low while the request buffer holds work");
      end

endmodule

bind sba_loader_top sba_loader_assert u_assert (
   .clk_sys     (clk_sys),
   .rst_i       (rst_i),
   .push_i      (push),
   .full_i      (full),
   .pop_i       (pop),
   .done_i      (done),
   .mem_ready_i (mem_ready_i),
   .not_empty_i (not_empty),
   .sbbusy_i    (u_regs.sbbusy)
);

`default_nettype wire

// File: hw/sba_loader_top.sv
//////////////////////////////
// Top of the SBA program-load path. DMI strobes in,
// register front end, request buffer and memory port
// in a chain. mem_ready_i stalls the SRAM side.
//////////////////////////////

`default_nettype none

module sba_loader_top (
   input  logic               clk_sys,
   input  logic               rst_i,
   input  logic               dmi_req_i,
   input  logic               dmi_we_i,
   input  sba_pkg::dmi_addr_t dmi_addr_i,
   input  sba_pkg::sba_word_t dmi_wdata_i,
   output sba_pkg::sba_word_t dmi_rdata_o,
   input  logic               mem_ready_i
);

   // front end to buffer
   logic              push;
   sba_pkg::sba_req_t req;
   logic              full;

   // buffer to memory port
   logic              not_empty;
   sba_pkg::sba_req_t head;
   logic              pop;

   // completions back to the front end
   logic               done;
   sba_pkg::sba_word_t rdata;

   dmi_sba_regs u_regs (
      .clk_sys     (clk_sys),
      .rst_i       (rst_i),
      .dmi_req_i   (dmi_req_i),
      .dmi_we_i    (dmi_we_i),
      .dmi_addr_i  (dmi_addr_i),
      .dmi_wdata_i (dmi_wdata_i),
      .dmi_rdata_o (dmi_rdata_o),
      .push_o      (push),
      .req_o       (req),
      .full_i      (full),
      .done_i      (done),
      .rdata_i     (rdata)
   );

   sba_req_fifo u_fifo (
      .clk_sys     (clk_sys),
      .rst_i       (rst_i),
      .push_i      (push),
      .req_i       (req),
      .full_o      (full),
      .pop_i       (pop),
      .head_o      (head),
      .not_empty_o (not_empty)
   );

   sba_mem_port u_mem (
      .clk_sys     (clk_sys),
      .rst_i       (rst_i),
      .not_empty_i (not_empty),
      .head_i      (head),
      .pop_o       (pop),
      .mem_ready_i (mem_ready_i),
      .done_o      (done),
      .rdata_o     (rdata)
   );

endmodule

`default_nettype wire

// File: hw/dmi_sba_regs.sv
//////////////////////////////
// DMI-facing SBA registers of the debug module.
// Holds SBCS, SBAddress0 and SBData0, turns DMI
// accesses into word requests for the buffer and
// tracks sbbusy, sbbusyerror and sberror.
// DMI reads return data in the next cycle.
//////////////////////////////

`default_nettype none

`include "sba_macros.svh"

module dmi_sba_regs (
   input  logic               clk_sys,
   input  logic               rst_i,
   input  logic               dmi_req_i,
   input  logic               dmi_we_i,
   input  sba_pkg::dmi_addr_t dmi_addr_i,
   input  sba_pkg::sba_word_t dmi_wdata_i,
   output sba_pkg::sba_word_t dmi_rdata_o,
   output logic               push_o,
   output sba_pkg::sba_req_t  req_o,
   input  logic               full_i,
   input  logic               done_i,
   input  sba_pkg::sba_word_t rdata_i
);

   localparam int DEPTH = `SBA_FIFO_DEPTH;
   // buffer entries plus the access in the memory port
   localparam int MAX_OUT = DEPTH + 1;
   localparam int CNT_W = $clog2(MAX_OUT + 1);

   // SBCS bit positions
   localparam int B_BUSYERR = 22;
   localparam int B_BUSY    = 21;
   localparam int B_RDONADR = 20;
   localparam int B_ACC_LO  = 17;
   localparam int B_AUTOINC = 16;
   localparam int B_RDONDAT = 15;
   localparam int B_ERR_LO  = 12;

   // SBCS fields
   logic              sbbusyerror;
   logic              sbbusy;
   logic              sbreadonaddr;
   logic [2:0]        sbaccess;
   logic              sbautoincrement;
   logic              sbreadondata;
   sba_pkg::sba_err_t sberror;

   sba_pkg::sba_word_t sbaddress0;
   sba_pkg::sba_word_t sbdata0;
   sba_pkg::sba_word_t sbcs_rd;

   // requests issued and not yet done
   logic [CNT_W-1:0] out_cnt;
   // read marker per outstanding request, bit 0 oldest
   logic [MAX_OUT-1:0] rd_flag;
   logic [MAX_OUT-1:0] rd_flag_n;
   logic [CNT_W-1:0]   slot;

   // decoded DMI accesses
   logic wr_sbcs;
   logic wr_addr;
   logic wr_data;
   logic rd_data;

   // request that the access asks for
   logic               want_req;
   logic               want_read;
   sba_pkg::sba_word_t want_addr;
   logic               size_ok;
   logic               fifo_blocked;
   logic               issue;

   assign wr_sbcs = dmi_req_i & dmi_we_i & (dmi_addr_i == sba_pkg::DMI_SBCS);
   assign wr_addr = dmi_req_i & dmi_we_i & (dmi_addr_i == sba_pkg::DMI_SBADDR0);
   assign wr_data = dmi_req_i & dmi_we_i & (dmi_addr_i == sba_pkg::DMI_SBDATA0);
   assign rd_data = dmi_req_i & ~dmi_we_i & (dmi_addr_i == sba_pkg::DMI_SBDATA0);

   // read on new address or after SBData0 is read out
   assign want_read = (wr_addr & sbreadonaddr) | (rd_data & sbreadondata);
   assign want_req  = wr_data | want_read;
   // a read on address uses the address being written
   assign want_addr = wr_addr ? dmi_wdata_i : sbaddress0;

   // only 32-bit accesses
   assign size_ok = (sbaccess == 3'd2);

   // full_i lags the push still in flight by one cycle
   // so the outstanding count covers that push
   assign fifo_blocked = full_i | (push_o & (out_cnt >= CNT_W'(DEPTH)));
   assign issue = want_req & size_ok & ~fifo_blocked;

   assign sbbusy = (out_cnt != '0);

   // new request goes behind the ones still pending
   assign slot = out_cnt - CNT_W'(done_i);

   always_comb begin
      rd_flag_n = rd_flag;
      if (done_i) begin
         rd_flag_n = rd_flag >> 1;
      end
      if (issue) begin
         rd_flag_n[slot] = want_read;
      end
   end

   // SBCS as seen on DMI
   // version, sbasize and size bits read as zero
   always_comb begin
      sbcs_rd = '0;
      sbcs_rd[B_BUSYERR] = sbbusyerror;
      sbcs_rd[B_BUSY] = sbbusy;
      sbcs_rd[B_RDONADR] = sbreadonaddr;
      sbcs_rd[B_ACC_LO+2:B_ACC_LO] = sbaccess;
      sbcs_rd[B_AUTOINC] = sbautoincrement;
      sbcs_rd[B_RDONDAT] = sbreadondata;
      sbcs_rd[B_ERR_LO+2:B_ERR_LO] = sberror;
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         push_o          <= 1'b0;
         out_cnt         <= '0;
         rd_flag         <= '0;
         sbbusyerror     <= 1'b0;
         sbreadonaddr    <= 1'b0;
         sbaccess        <= 3'd0;
         sbautoincrement <= 1'b0;
         sbreadondata    <= 1'b0;
         sberror         <= sba_pkg::SBERR_NONE;
         sbaddress0      <= '0;
         sbdata0         <= '0;
      end else begin
         push_o  <= issue;
         // busy rises on the issuing edge
         out_cnt <= out_cnt + CNT_W'(issue) - CNT_W'(done_i);
         rd_flag <= rd_flag_n;

         if (wr_sbcs) begin
            sbreadonaddr    <= dmi_wdata_i[B_RDONADR];
            sbaccess        <= dmi_wdata_i[B_ACC_LO+2:B_ACC_LO];
            sbautoincrement <= dmi_wdata_i[B_AUTOINC];
            sbreadondata    <= dmi_wdata_i[B_RDONDAT];
            // write 1 to clear
            if (dmi_wdata_i[B_BUSYERR]) begin
               sbbusyerror <= 1'b0;
            end
            // all ones clears the error code
            if (dmi_wdata_i[B_ERR_LO+2:B_ERR_LO] == 3'b111) begin
               sberror <= sba_pkg::SBERR_NONE;
            end
         end

         // refused requests are lost
         if (want_req & ~size_ok) begin
            sberror <= sba_pkg::SBERR_SIZE;
         end else if (want_req & fifo_blocked) begin
            sbbusyerror <= 1'b1;
         end

         if (wr_addr) begin
            sbaddress0 <= dmi_wdata_i;
         end
         // next word after each issued request
         if (issue & sbautoincrement) begin
            sbaddress0 <= want_addr + 32'd4;
         end

         // completed read lands in SBData0
         if (done_i & rd_flag[0]) begin
            sbdata0 <= rdata_i;
         end
         // host write wins over returning data
         if (wr_data) begin
            sbdata0 <= dmi_wdata_i;
         end
      end
   end

   // request payload
   always_ff @(posedge clk_sys) begin
      if (issue) begin
         req_o.we    <= wr_data;
         req_o.addr  <= want_addr;
         req_o.wdata <= dmi_wdata_i;
      end
   end

   // DMI read data, old SBData0 goes out before a read on data
   always_ff @(posedge clk_sys) begin
      if (dmi_req_i & ~dmi_we_i) begin
         case (dmi_addr_i)
            sba_pkg::DMI_SBCS:    dmi_rdata_o <= sbcs_rd;
            sba_pkg::DMI_SBADDR0: dmi_rdata_o <= sbaddress0;
            sba_pkg::DMI_SBDATA0: dmi_rdata_o <= sbdata0;
            default:              dmi_rdata_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/sba_mem_port.sv
//////////////////////////////
// Memory side of the SBA path. Owns the word SRAM
// and drains one request per cycle in which the
// buffer has work and mem_ready_i is high.
// done_o pulses one cycle after each access and
// carries the read data for reads.
//////////////////////////////

`default_nettype none

`include "sba_macros.svh"

module sba_mem_port (
   input  logic               clk_sys,
   input  logic               rst_i,
   input  logic               not_empty_i,
   input  sba_pkg::sba_req_t  head_i,
   output logic               pop_o,
   input  logic               mem_ready_i,
   output logic               done_o,
   output sba_pkg::sba_word_t rdata_o
);

   localparam int WORDS = `SBA_MEM_WORDS;
   localparam int IDX_W = $clog2(WORDS);

   // word-addressed array
   sba_pkg::sba_word_t sram [WORDS];

   // access taken this cycle
   logic fire;
   // word index of the head request
   logic [IDX_W-1:0] idx;

   // stall when the slave is not ready
   assign fire  = not_empty_i & mem_ready_i;

   // pop in the same cycle so the buffer
   // advances on the edge of the access
   assign pop_o = fire;

   // byte address to word index
   // upper bits drop so the array wraps
   assign idx = head_i.addr[IDX_W+1:2];

   // completion strobe
   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         done_o <= 1'b0;
      end else begin
         done_o <= fire;
      end
   end

   // sram access
   always_ff @(posedge clk_sys) begin
      if (fire) begin
         if (head_i.we) begin
            sram[idx] <= head_i.wdata;
         end else begin
            // read data lines up with done_o
            rdata_o <= sram[idx];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/sba_req_fifo.sv
//////////////////////////////
// Request buffer between the SBA register front end
// and the memory port. Lets several requests wait
// while the SRAM stalls. Push is dropped when full
// and pop is ignored when empty.
//////////////////////////////

`default_nettype none

`include "sba_macros.svh"

module sba_req_fifo #(
   parameter int DEPTH = `SBA_FIFO_DEPTH
) (
   input  logic              clk_sys,
   input  logic              rst_i,
   input  logic              push_i,
   input  sba_pkg::sba_req_t req_i,
   output logic              full_o,
   input  logic              pop_i,
   output sba_pkg::sba_req_t head_o,
   output logic              not_empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // request storage
   sba_pkg::sba_req_t slots [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // entries held
   logic [CNT_W-1:0] count;

   logic do_push;
   logic do_pop;

   // pointer step with wrap for any depth
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1)) begin
         ptr_next = '0;
      end else begin
         ptr_next = p + 1'b1;
      end
   endfunction

   assign full_o      = (count == CNT_W'(DEPTH));
   assign not_empty_o = (count != '0);
   assign head_o      = slots[rd_ptr];

   // guard against misuse from either side
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & not_empty_o;

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         // push and pop together leave the count as is
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   // storage write
   always_ff @(posedge clk_sys) begin
      if (do_push) begin
         slots[wr_ptr] <= req_i;
      end
   end

endmodule

`default_nettype wire

// File: hw/sba_pkg.sv
//////////////////////////////
// Shared types for the system bus access path.
// Refer to the names with sba_pkg:: scoping.
//////////////////////////////

`default_nettype none

`include "sba_macros.svh"

package sba_pkg;

   // DMI register address
   typedef logic [`SBA_DMI_AW-1:0] dmi_addr_t;

   // data word or byte address
   typedef logic [`SBA_DW-1:0] sba_word_t;

   // sberror field of SBCS
   typedef logic [2:0] sba_err_t;

   // sberror codes in use
   localparam sba_err_t SBERR_NONE = 3'd0;
   localparam sba_err_t SBERR_SIZE = 3'd4;

   // DMI addresses of the SBA registers
   localparam dmi_addr_t DMI_SBCS    = 7'h38;
   localparam dmi_addr_t DMI_SBADDR0 = 7'h39;
   localparam dmi_addr_t DMI_SBDATA0 = 7'h3C;

   // one word access toward memory
   typedef struct packed {
      // 1 for a write, 0 for a read
      logic      we;
      // byte address, low two bits ignored
      sba_word_t addr;
      // unused for reads
      sba_word_t wdata;
   } sba_req_t;

endpackage

`default_nettype wire

// File: hw/sba_macros.svh
//////////////////////////////
// Build-time sizes for the system bus access path.
// Include this in any file that needs a width or depth
// and take the types from the package instead.
//////////////////////////////

`ifndef SBA_MACROS_SVH
`define SBA_MACROS_SVH

// width of the DMI register address
`define SBA_DMI_AW 7

// data word and byte address width
// only 32-bit accesses are served
`define SBA_DW 32

// request buffer depth in entries
`define SBA_FIFO_DEPTH 4

// SRAM size in 32-bit words
// must be a power of two so that the index wraps
`define SBA_MEM_WORDS 256

`endif
